// ==== vlog.f ====
common/cache_pkg.sv
common/bus_pkg.sv
rtl/cpu_port.sv
dcache/dcache_store.sv
dcache/dcache_ctrl.sv
rtl/wb_burst_master.sv
rtl/dcache_top.sv
sim/wb_mem_model.sv
sim/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - common/cache_pkg.sv
  - common/bus_pkg.sv
  - rtl/cpu_port.sv
  - dcache/dcache_store.sv
  - dcache/dcache_ctrl.sv
  - rtl/wb_burst_master.sv
  - rtl/dcache_top.sv
  - target: simulation
    files:
      - sim/wb_mem_model.sv
      - sim/dcache_tb.sv

// ==== sim/dcache_tb.sv ====
module dcache_tb;

	localparam int num_random = 400;
	localparam int num_directed = 8;
	// a random request may be followed by a repeat read
	localparam int max_cycles = (2 * num_random + num_directed) * 40;
	localparam int win_words = 2048;

	logic clk;
	logic rst_n;
	logic req_valid;
	bus_pkg::cpu_req_t req;
	logic done;
	bus_pkg::cpu_resp_t resp;
	bus_pkg::wb_m2s_t wb_out;
	bus_pkg::wb_s2m_t wb_in;

	integer seed;
	int value_errors = 0;
	int bus_errors = 0;
	int cycles = 0;
	logic [63:0] model_mem [win_words];
	logic prev_cyc;
	int beats;
	logic [31:0] burst_base;

	dcache_top dcache_top_inst (
		.clk, .rst_n, .req_valid, .req, .done, .resp, .wb_out, .wb_in
	);

	wb_mem_model wb_mem_model_inst (.clk, .rst_n, .m2s(wb_out), .s2m(wb_in));

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the cache stopped answering", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// wishbone burst shape sampled mid cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_cyc = 1'b0;
		end else begin
			if (wb_out.stb && !wb_out.cyc) begin
				$display("stb high without cyc at %0t", $time);
				bus_errors++;
			end
			if (wb_out.cyc && !prev_cyc) begin
				beats = 0;
			end
			if (wb_out.stb && wb_in.ack) begin
				if (beats == 0) begin
					burst_base = wb_out.adr;
					if (burst_base[4:0] != 5'd0) begin
						$display("burst at %0t does not start on a line base", $time);
						bus_errors++;
					end
				end
				if (wb_out.adr !== burst_base + 32'(8 * beats)) begin
					$display("Mismatch at %0t: wb_out.adr got %h expected %h", $time,
						wb_out.adr, burst_base + 32'(8 * beats));
					bus_errors++;
				end
				if (wb_out.sel !== 8'hff) begin
					$display("Mismatch at %0t: wb_out.sel got %h expected ff", $time, wb_out.sel);
					bus_errors++;
				end
				beats++;
			end
			if (!wb_out.cyc && prev_cyc && beats != 4) begin
				$display("burst ending at %0t had %0d beats instead of 4", $time, beats);
				bus_errors++;
			end
			prev_cyc = wb_out.cyc;
		end
	end

	// one request held until done
	// lat counts edges after the sampling edge
	task automatic cpu_access(input logic [31:0] addr, input logic we,
			input logic [63:0] wdata, input logic [7:0] wmask, output int lat);
		int k;
		int w;
		logic [63:0] want;
		w = addr[13:3];
		want = we ? 64'd0 : model_mem[w];
		req.addr = addr;
		req.we = we;
		req.wdata = wdata;
		req.wmask = wmask;
		req_valid = 1'b1;
		k = 0;
		do begin
			@(negedge clk);
			k++;
		end while (!done);
		lat = k - 1;
		if (resp.rdata !== want) begin
			$display("Mismatch at %0t: resp.rdata got %h expected %h (addr %h)", $time,
				resp.rdata, want, addr);
			value_errors++;
		end
		if (we) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask[b]) begin
					model_mem[w][8*b +: 8] = wdata[8*b +: 8];
				end
			end
		end
		req_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic random_request();
		logic [31:0] addr;
		logic we;
		logic [63:0] wdata;
		logic [7:0] wmask;
		int lat;
		addr = 32'($random(seed)) & 32'h0000_3ff8;
		we = 1'($random(seed));
		wdata = {$random(seed), $random(seed)};
		wmask = 8'($random(seed));
		cpu_access(addr, we, wdata, wmask, lat);
		if (($random(seed) & 3) == 0) begin
			cpu_access(addr, 1'b0, '0, '0, lat); // line is resident now
			if (lat != 2) begin
				$display("Mismatch at %0t: done latency got %0d expected 2", $time, lat);
				value_errors++;
			end
		end
	endtask

	initial begin
		int lat;
		int line_w;
		logic [31:0] a;
		seed = 32'h24bd61fd;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < win_words; i++) begin
			model_mem[i] = {32'(i * 8), ~32'(i * 8)};
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (done || wb_out.cyc || wb_out.stb) begin
				$display("done, cyc or stb went high at %0t with no request", $time);
				bus_errors++;
			end
		end

		// set 5 with tags 1 to 3
		// the third write pushes out the first line
		a = 32'h0000_08a8;
		cpu_access(a, 1'b1, 64'h1111_2222_3333_4444, 8'hff, lat);
		cpu_access(32'h0000_10a8, 1'b1, 64'h5555_6666_7777_8888, 8'hff, lat);
		cpu_access(32'h0000_18a8, 1'b1, 64'h9999_aaaa_bbbb_cccc, 8'hff, lat);
		line_w = {a[13:5], 2'b00};
		for (int i = 0; i < 4; i++) begin
			if (wb_mem_model_inst.mem[line_w + i] !== model_mem[line_w + i]) begin
				$display("Mismatch at %0t: mem[%0d] got %h expected %h", $time, line_w + i,
					wb_mem_model_inst.mem[line_w + i], model_mem[line_w + i]);
				value_errors++;
			end
		end
		cpu_access(a, 1'b0, '0, '0, lat);
		cpu_access(32'h0000_10a8, 1'b0, '0, '0, lat);
		cpu_access(32'h0000_18a8, 1'b0, '0, '0, lat);
		cpu_access(a, 1'b1, 64'hdead_beef_0bad_f00d, 8'h5a, lat); // partial mask
		cpu_access(a, 1'b0, '0, '0, lat);
		if (lat != 2) begin
			$display("Mismatch at %0t: done latency got %0d expected 2", $time, lat);
			value_errors++;
		end

		repeat (num_random) random_request();

		$display("errors: %0d value, %0d bus, after %0d cycles", value_errors, bus_errors,
			cycles);
		if (value_errors == 0 && bus_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== sim/wb_mem_model.sv ====
module wb_mem_model (
	input  logic clk,
	input  logic rst_n,
	input  bus_pkg::wb_m2s_t m2s,
	output bus_pkg::wb_s2m_t s2m
);

	localparam int depth = 2048; // 16 KiB window at address zero

	logic [cache_pkg::data_w-1:0] mem [depth];
	logic [1:0] delay;
	logic [10:0] widx;
	integer seed;

	assign widx = m2s.adr[13:3];

	// byte address in the upper half, its inverse in the lower half
	initial begin
		seed = 32'h24bd61fd;
		for (int i = 0; i < depth; i++) begin
			mem[i] = {32'(i * 8), ~32'(i * 8)};
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			s2m.ack <= 1'b0;
			s2m.dat <= '0;
			delay <= 2'd0;
		end else begin
			s2m.ack <= 1'b0;
			if (m2s.cyc && m2s.stb && !s2m.ack) begin
				if (delay == 2'd0) begin
					s2m.ack <= 1'b1;
					delay <= 2'($random(seed)); // wait before the next ack
					if (m2s.we) begin
						for (int b = 0; b < cache_pkg::mask_w; b++) begin
							if (m2s.sel[b]) begin
								mem[widx][8*b +: 8] <= m2s.dat[8*b +: 8];
							end
						end
					end else begin
						s2m.dat <= mem[widx];
					end
				end else begin
					delay <= delay - 2'd1;
				end
			end
		end
	end

endmodule

// ==== rtl/dcache_top.sv ====
module dcache_top (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	input  bus_pkg::cpu_req_t req,
	output logic done,
	output bus_pkg::cpu_resp_t resp,
	output bus_pkg::wb_m2s_t wb_out,
	input  bus_pkg::wb_s2m_t wb_in
);

	bus_pkg::cpu_req_t cur_req;
	logic new_req;
	logic finish;
	logic [cache_pkg::data_w-1:0] finish_data;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	cache_pkg::tag_t victim_tag;
	cache_pkg::line_t victim_line;
	logic [cache_pkg::data_w-1:0] read_word;
	logic word_we;
	logic line_we;
	logic touch;
	logic wr_way;
	bus_pkg::line_cmd_t cmd;
	logic line_start;
	logic line_done;
	cache_pkg::line_t fill_line;

	cpu_port cpu_port_inst (
		.clk, .rst_n, .req_valid, .req, .finish, .finish_data,
		.done, .resp, .cur_req, .new_req
	);

	dcache_ctrl dcache_ctrl_inst (
		.clk, .rst_n, .cur_req, .new_req, .hit, .hit_way, .victim_way,
		.victim_dirty, .victim_tag, .victim_line, .read_word, .line_done,
		.fill_line, .finish, .finish_data, .word_we, .line_we, .touch,
		.wr_way, .cmd, .line_start
	);

	dcache_store dcache_store_inst (
		.clk, .rst_n, .addr(cur_req.addr), .word_we, .line_we, .touch, .wr_way,
		.wdata(cur_req.wdata), .wmask(cur_req.wmask), .fill_line, .hit, .hit_way,
		.victim_way, .victim_dirty, .victim_tag, .victim_line, .read_word
	);

	wb_burst_master wb_burst_master_inst (
		.clk, .rst_n, .line_start, .cmd, .wb_in, .wb_out, .line_done, .fill_line
	);

endmodule

// ==== rtl/wb_burst_master.sv ====
module wb_burst_master (
	input  logic clk,
	input  logic rst_n,
	input  logic line_start,
	input  bus_pkg::line_cmd_t cmd,
	input  bus_pkg::wb_s2m_t wb_in,
	output bus_pkg::wb_m2s_t wb_out,
	output logic line_done,
	output cache_pkg::line_t fill_line
);

	bus_pkg::line_cmd_t cmd_q;
	logic cyc_q;
	logic stb_q;
	logic [1:0] beat_q;
	logic beat_ack;
	logic last_beat;

	assign beat_ack = stb_q && wb_in.ack;
	assign last_beat = beat_q == 2'(cache_pkg::words_per_line - 1);

	always_comb begin
		wb_out.cyc = cyc_q;
		wb_out.stb = stb_q;
		wb_out.we = cmd_q.op == bus_pkg::op_write_line;
		wb_out.adr = {cmd_q.tag, cmd_q.index, beat_q, 3'b000};
		wb_out.dat = cmd_q.data[beat_q];
		wb_out.sel = '1; // whole words only
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			beat_q <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			if (line_start) begin
				cyc_q <= 1'b1;
				stb_q <= 1'b1;
				beat_q <= '0;
			end else if (beat_ack) begin
				stb_q <= 1'b0; // one idle cycle between beats
				if (last_beat) begin
					cyc_q <= 1'b0;
					line_done <= 1'b1;
				end else begin
					beat_q <= beat_q + 2'd1;
				end
			end else if (cyc_q) begin
				stb_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			cmd_q <= cmd;
		end
		if (beat_ack && cmd_q.op == bus_pkg::op_read_line) begin
			fill_line[beat_q] <= wb_in.dat;
		end
	end

	a_stb_needs_cyc: assert property (
		@(posedge clk) disable iff (!rst_n) wb_out.stb |-> wb_out.cyc
	);

endmodule

// ==== dcache/dcache_ctrl.sv ====
module dcache_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  bus_pkg::cpu_req_t cur_req,
	input  logic new_req,
	input  logic hit,
	input  logic hit_way,
	input  logic victim_way,
	input  logic victim_dirty,
	input  cache_pkg::tag_t victim_tag,
	input  cache_pkg::line_t victim_line,
	input  logic [cache_pkg::data_w-1:0] read_word,
	input  logic line_done,
	input  cache_pkg::line_t fill_line,
	output logic finish,
	output logic [cache_pkg::data_w-1:0] finish_data,
	output logic word_we,
	output logic line_we,
	output logic touch,
	output logic wr_way,
	output bus_pkg::line_cmd_t cmd,
	output logic line_start
);

	cache_pkg::ctrl_state_e state;
	logic vict_q; // way chosen at the miss
	logic lookup;
	logic hit_now;
	logic miss_now;
	cache_pkg::tag_t req_tag;
	logic [cache_pkg::index_w-1:0] req_index;
	logic [1:0] req_word;

	assign req_tag = cur_req.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
	assign req_index = cur_req.addr[cache_pkg::offset_w +: cache_pkg::index_w];
	assign req_word = cur_req.addr[cache_pkg::offset_w-1:3];

	// first lookup overlaps the new_req cycle
	assign lookup = (state == cache_pkg::s_idle && new_req) || state == cache_pkg::s_lookup;
	assign hit_now = lookup && hit;
	assign miss_now = lookup && !hit;

	assign finish = state == cache_pkg::s_respond;

	always_comb begin
		word_we = hit_now && cur_req.we;
		touch = hit_now && !cur_req.we;
		line_we = state == cache_pkg::s_refill && line_done; // fill_line valid with line_done
		wr_way = (state == cache_pkg::s_refill) ? vict_q : hit_way;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::s_idle;
			line_start <= 1'b0;
			vict_q <= 1'b0;
		end else begin
			line_start <= 1'b0;
			case (state)
				cache_pkg::s_idle, cache_pkg::s_lookup: begin
					if (hit_now) begin
						state <= cache_pkg::s_respond;
					end else if (miss_now) begin
						vict_q <= victim_way;
						line_start <= 1'b1;
						state <= victim_dirty ? cache_pkg::s_write_back : cache_pkg::s_refill;
					end
				end
				cache_pkg::s_write_back: begin
					if (line_done) begin
						line_start <= 1'b1; // refill right behind the write-back
						state <= cache_pkg::s_refill;
					end
				end
				cache_pkg::s_refill: begin
					if (line_done) begin
						state <= cache_pkg::s_lookup;
					end
				end
				cache_pkg::s_respond: state <= cache_pkg::s_idle;
				default: state <= cache_pkg::s_idle;
			endcase
		end
	end

	// command and response payload
	always_ff @(posedge clk) begin
		if (miss_now) begin
			cmd.op <= victim_dirty ? bus_pkg::op_write_line : bus_pkg::op_read_line;
			cmd.tag <= victim_dirty ? victim_tag : req_tag;
			cmd.index <= req_index;
			cmd.data <= victim_line;
		end else if (state == cache_pkg::s_write_back && line_done) begin
			cmd.op <= bus_pkg::op_read_line;
			cmd.tag <= req_tag;
		end
		if (hit_now) begin
			finish_data <= cur_req.we ? '0 : read_word;
		end
	end

	a_start_in_burst_state: assert property (
		@(posedge clk) disable iff (!rst_n)
		line_start |-> state inside {cache_pkg::s_write_back, cache_pkg::s_refill}
	);

	a_finish_pulse: assert property (
		@(posedge clk) disable iff (!rst_n) finish |=> !finish
	);

	// installed line must serve the repeated lookup
	a_install_hits: assert property (
		@(posedge clk) disable iff (!rst_n)
		line_we |=> hit && read_word == $past(fill_line[req_word])
	);

endmodule

// ==== dcache/dcache_store.sv ====
module dcache_store (
	input  logic clk,
	input  logic rst_n,
	input  logic [cache_pkg::addr_w-1:0] addr,
	input  logic word_we,
	input  logic line_we,
	input  logic touch,
	input  logic wr_way,
	input  logic [cache_pkg::data_w-1:0] wdata,
	input  logic [cache_pkg::mask_w-1:0] wmask,
	input  cache_pkg::line_t fill_line,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output cache_pkg::tag_t victim_tag,
	output cache_pkg::line_t victim_line,
	output logic [cache_pkg::data_w-1:0] read_word
);

	cache_pkg::tag_t tag_q [cache_pkg::num_ways][cache_pkg::num_sets];
	cache_pkg::line_t data_q [cache_pkg::num_ways][cache_pkg::num_sets];
	logic [cache_pkg::num_ways-1:0][cache_pkg::num_sets-1:0] valid_q;
	logic [cache_pkg::num_ways-1:0][cache_pkg::num_sets-1:0] dirty_q;
	logic [cache_pkg::num_sets-1:0] lru_q; // names the least recently used way

	cache_pkg::tag_t tag;
	logic [cache_pkg::index_w-1:0] idx;
	logic [1:0] word_sel;
	logic [cache_pkg::num_ways-1:0] way_hit;

	assign tag = addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
	assign idx = addr[cache_pkg::offset_w +: cache_pkg::index_w];
	assign word_sel = addr[cache_pkg::offset_w-1:3];

	always_comb begin
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			way_hit[w] = valid_q[w][idx] && tag_q[w][idx] == tag;
		end
		hit = |way_hit;
		hit_way = way_hit[1];
		// empty way first, else lru
		if (!valid_q[0][idx]) begin
			victim_way = 1'b0;
		end else if (!valid_q[1][idx]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[idx];
		end
		victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
		victim_tag = tag_q[victim_way][idx];
		victim_line = data_q[victim_way][idx];
		read_word = data_q[hit_way][idx][word_sel];
	end

	// arrays
	always_ff @(posedge clk) begin
		if (line_we) begin
			data_q[wr_way][idx] <= fill_line;
			tag_q[wr_way][idx] <= tag;
		end else if (word_we) begin
			for (int b = 0; b < cache_pkg::mask_w; b++) begin
				if (wmask[b]) begin
					data_q[wr_way][idx][word_sel][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			if (line_we) begin
				valid_q[wr_way][idx] <= 1'b1;
				dirty_q[wr_way][idx] <= 1'b0; // clean after refill
			end else if (word_we) begin
				dirty_q[wr_way][idx] <= 1'b1;
			end
			if (word_we || touch) begin
				lru_q[idx] <= !wr_way;
			end
		end
	end

	a_single_way_hit: assert property (
		@(posedge clk) disable iff (!rst_n) $onehot0(way_hit)
	);

endmodule

// ==== rtl/cpu_port.sv ====
module cpu_port (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	input  bus_pkg::cpu_req_t req,
	input  logic finish,
	input  logic [cache_pkg::data_w-1:0] finish_data,
	output logic done,
	output bus_pkg::cpu_resp_t resp,
	output bus_pkg::cpu_req_t cur_req,
	output logic new_req
);

	logic busy;
	logic accept;

	// the done cycle still belongs to the old request
	assign accept = req_valid && !busy && !done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			new_req <= 1'b0;
			done <= 1'b0;
		end else begin
			new_req <= accept;
			done <= finish;
			if (accept) begin
				busy <= 1'b1;
			end else if (finish) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_req <= req; // held for the whole access
		end
		if (finish) begin
			resp.rdata <= finish_data;
		end
	end

	// controller only answers a request it was given
	a_finish_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n) finish |-> busy
	);

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

	typedef struct packed {
		logic [cache_pkg::addr_w-1:0] addr;
		logic we;
		logic [cache_pkg::data_w-1:0] wdata;
		logic [cache_pkg::mask_w-1:0] wmask;
	} cpu_req_t;

	typedef struct packed {
		logic [cache_pkg::data_w-1:0] rdata; // zero on writes
	} cpu_resp_t;

	typedef enum logic {
		op_read_line,
		op_write_line
	} line_op_e;

	typedef struct packed {
		line_op_e op;
		cache_pkg::tag_t tag;
		logic [cache_pkg::index_w-1:0] index;
		cache_pkg::line_t data; // only meaningful for write-back
	} line_cmd_t;

	// wishbone classic
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [cache_pkg::addr_w-1:0] adr;
		logic [cache_pkg::data_w-1:0] dat;
		logic [cache_pkg::mask_w-1:0] sel;
	} wb_m2s_t;

	typedef struct packed {
		logic [cache_pkg::data_w-1:0] dat;
		logic ack;
	} wb_s2m_t;

endpackage

// ==== common/cache_pkg.sv ====
package cache_pkg;

	// geometry
	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int mask_w = 8; // one bit per byte of a data word
	localparam int words_per_line = 4;
	localparam int num_sets = 64;
	localparam int num_ways = 2;

	// address fields: tag [31:11], index [10:5], word [4:3]
	localparam int offset_w = 5;
	localparam int index_w = 6;
	localparam int tag_w = 21;

	typedef logic [tag_w-1:0] tag_t;

	// word 0 sits at the line base
	typedef logic [words_per_line-1:0][data_w-1:0] line_t;

	typedef enum logic [2:0] {
		s_idle,
		s_lookup, // repeat lookup after a refill
		s_write_back,
		s_refill,
		s_respond
	} ctrl_state_e;

endpackage
